// File: dg_pkg.sv
`default_nettype none

package dg_pkg;

    // lattice size
    localparam int unsigned code_distance_x = 3;   // rows
    localparam int unsigned code_distance_z = 2;   // columns
    localparam int unsigned measurement_rounds = 3;   // layers
    localparam int unsigned pu_count = code_distance_x * code_distance_z * measurement_rounds;

    // address is {layer, row, column}
    localparam int unsigned per_dim_bit_width = 2;
    localparam int unsigned address_width = 3 * per_dim_bit_width;

    // neighbor index of each direction
    localparam int unsigned neighbor_count = 6;
    localparam int unsigned dir_north = 0;
    localparam int unsigned dir_south = 1;
    localparam int unsigned dir_west = 2;
    localparam int unsigned dir_east = 3;
    localparam int unsigned dir_down = 4;
    localparam int unsigned dir_up = 5;

    // growth needed to fill a link along each axis
    localparam int unsigned weight_x = 2;   // north/south
    localparam int unsigned weight_z = 2;   // east/west
    localparam int unsigned weight_m = 2;   // up/down, between rounds
    localparam int unsigned growth_width = 2;

    typedef logic [address_width-1:0] address_t;
    typedef logic [growth_width-1:0] growth_t;

    typedef enum logic [2:0] {
        stage_idle = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_grow = 3'd2,
        stage_merge = 3'd3
    } stage_t;

    typedef enum logic [1:0] {
        link_internal = 2'd0,
        link_boundary = 2'd1,
        link_none = 2'd2   // open end, never grows
    } link_kind_t;

    typedef struct packed {
        logic defect;
        address_t root;
        logic touching_boundary;
    } pu_state_t;

    typedef struct packed {
        logic fully_grown;
        address_t root;   // far unit's root
        logic touching_boundary;
    } link_view_t;

    // position in the flat per-unit vectors
    function automatic int unsigned pu_index(int unsigned row, int unsigned col,
                                             int unsigned layer);
        return row * code_distance_z + col + layer * code_distance_z * code_distance_x;
    endfunction

    function automatic address_t pu_address(int unsigned row, int unsigned col,
                                            int unsigned layer);
        return {layer[per_dim_bit_width-1:0], row[per_dim_bit_width-1:0],
                col[per_dim_bit_width-1:0]};
    endfunction

endpackage

`default_nettype wire

// File: neighbor_link.sv
`timescale 1ns/100ps
`default_nettype none

module neighbor_link #(
    parameter dg_pkg::link_kind_t kind = dg_pkg::link_internal,
    parameter int unsigned weight = dg_pkg::weight_x
) (
    input  logic clk,
    input  logic rst_n,
    input  dg_pkg::stage_t global_stage,
    input  dg_pkg::pu_state_t a_state,
    input  dg_pkg::pu_state_t b_state,
    output dg_pkg::link_view_t a_view,
    output dg_pkg::link_view_t b_view
);

    generate
        if (kind == dg_pkg::link_none) begin : g_none
            // lattice edge without a boundary, the endpoint never sees it grown
            assign a_view = '0;
            assign b_view = '0;
        end else begin : g_grow
            dg_pkg::growth_t growth;
            dg_pkg::growth_t growth_next;
            logic [1:0] inc;   // endpoints with a defect this cycle
            logic [dg_pkg::growth_width:0] sum;
            logic fully_grown;

            always_comb begin
                sum = {1'b0, growth} + {1'b0, inc};
                if (sum >= weight) begin
                    growth_next = dg_pkg::growth_t'(weight);   // saturate
                end else begin
                    growth_next = sum[dg_pkg::growth_width-1:0];
                end
            end

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    growth <= '0;
                    fully_grown <= 1'b0;
                end else begin
                    case (global_stage)
                        dg_pkg::stage_measurement_loading: begin
                            growth <= '0;
                            fully_grown <= 1'b0;
                        end
                        dg_pkg::stage_grow: begin
                            growth <= growth_next;
                            fully_grown <= (growth_next == dg_pkg::growth_t'(weight));
                        end
                        default: begin
                        end
                    endcase
                end
            end

            if (kind == dg_pkg::link_internal) begin : g_internal
                assign inc = {1'b0, a_state.defect} + {1'b0, b_state.defect};

                // each side sees the other side's cluster
                assign a_view = '{
                    fully_grown: fully_grown,
                    root: b_state.root,
                    touching_boundary: b_state.touching_boundary
                };
                assign b_view = '{
                    fully_grown: fully_grown,
                    root: a_state.root,
                    touching_boundary: a_state.touching_boundary
                };
            end else begin : g_boundary
                assign inc = {1'b0, a_state.defect};

                // own root echoed back so the minimum is not disturbed
                assign a_view = '{
                    fully_grown: fully_grown,
                    root: a_state.root,
                    touching_boundary: fully_grown
                };
                assign b_view = '0;   // no far side
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: processing_unit.sv
`timescale 1ns/100ps
`default_nettype none

module processing_unit #(
    parameter dg_pkg::address_t address = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  dg_pkg::stage_t global_stage,
    input  logic measurement,
    input  dg_pkg::link_view_t views [dg_pkg::neighbor_count],
    output dg_pkg::pu_state_t state,
    output logic busy
);

    logic defect;
    dg_pkg::address_t root;
    logic touching_boundary;
    dg_pkg::address_t root_next;
    logic touching_boundary_next;
    logic root_changed;
    logic boundary_changed;

    // smallest root and boundary contact over the fully grown links
    always_comb begin
        root_next = root;
        touching_boundary_next = touching_boundary;
        for (int n = 0; n < dg_pkg::neighbor_count; n++) begin
            if (views[n].fully_grown) begin
                if (views[n].root < root_next) begin
                    root_next = views[n].root;
                end
                touching_boundary_next = touching_boundary_next | views[n].touching_boundary;
            end
        end
    end

    assign root_changed = (root_next != root);
    assign boundary_changed = (touching_boundary_next != touching_boundary);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            defect <= 1'b0;
            root <= address;
            touching_boundary <= 1'b0;
            busy <= 1'b0;
        end else begin
            case (global_stage)
                dg_pkg::stage_measurement_loading: begin
                    defect <= measurement;
                    root <= address;   // every unit starts as its own cluster
                    touching_boundary <= 1'b0;
                    busy <= 1'b0;
                end
                dg_pkg::stage_merge: begin
                    root <= root_next;
                    touching_boundary <= touching_boundary_next;
                    busy <= root_changed | boundary_changed;   // not settled yet
                end
                default: begin
                end
            endcase
        end
    end

    assign state = '{
        defect: defect,
        root: root,
        touching_boundary: touching_boundary
    };

endmodule

`default_nettype wire

// File: decoding_graph.sv
`timescale 1ns/100ps
`default_nettype none

module decoding_graph (
    input  logic clk,
    input  logic rst_n,
    input  dg_pkg::stage_t global_stage,
    input  logic [dg_pkg::pu_count-1:0] measurements,
    output dg_pkg::address_t [dg_pkg::pu_count-1:0] roots,
    output logic [dg_pkg::pu_count-1:0] touching_boundary,
    output logic [dg_pkg::pu_count-1:0] busy
);

    dg_pkg::pu_state_t states [dg_pkg::pu_count];
    dg_pkg::link_view_t views [dg_pkg::pu_count][dg_pkg::neighbor_count];

    // units, indexed by row * columns + column + layer * layer size
    for (genvar k = 0; k < dg_pkg::measurement_rounds; k++) begin : g_pu_layer
        for (genvar i = 0; i < dg_pkg::code_distance_x; i++) begin : g_pu_row
            for (genvar j = 0; j < dg_pkg::code_distance_z; j++) begin : g_pu_col
                processing_unit #(
                    .address(dg_pkg::pu_address(i, j, k))
                ) unit_i (
                    .clk(clk),
                    .rst_n(rst_n),
                    .global_stage(global_stage),
                    .measurement(measurements[dg_pkg::pu_index(i, j, k)]),
                    .views(views[dg_pkg::pu_index(i, j, k)]),
                    .state(states[dg_pkg::pu_index(i, j, k)]),
                    .busy(busy[dg_pkg::pu_index(i, j, k)])
                );

                assign roots[dg_pkg::pu_index(i, j, k)] = states[dg_pkg::pu_index(i, j, k)].root;
                assign touching_boundary[dg_pkg::pu_index(i, j, k)] =
                    states[dg_pkg::pu_index(i, j, k)].touching_boundary;
            end
        end
    end

    // north/south links, open at both ends of each column
    for (genvar k = 0; k < dg_pkg::measurement_rounds; k++) begin : g_ns_layer
        for (genvar i = 0; i <= dg_pkg::code_distance_x; i++) begin : g_ns_row
            for (genvar j = 0; j < dg_pkg::code_distance_z; j++) begin : g_ns_col
                if (i == 0) begin : g_first
                    neighbor_link #(
                        .kind(dg_pkg::link_none),
                        .weight(dg_pkg::weight_x)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j, k)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_south]),
                        .b_view()
                    );
                end else if (i < dg_pkg::code_distance_x) begin : g_inner
                    neighbor_link #(
                        .kind(dg_pkg::link_internal),
                        .weight(dg_pkg::weight_x)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i - 1, j, k)]),
                        .b_state(states[dg_pkg::pu_index(i, j, k)]),
                        .a_view(views[dg_pkg::pu_index(i - 1, j, k)][dg_pkg::dir_north]),
                        .b_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_south])
                    );
                end else begin : g_last
                    neighbor_link #(
                        .kind(dg_pkg::link_none),
                        .weight(dg_pkg::weight_x)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i - 1, j, k)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i - 1, j, k)][dg_pkg::dir_north]),
                        .b_view()
                    );
                end
            end
        end
    end

    // east/west links, boundary at both ends of each row
    for (genvar k = 0; k < dg_pkg::measurement_rounds; k++) begin : g_ew_layer
        for (genvar i = 0; i < dg_pkg::code_distance_x; i++) begin : g_ew_row
            for (genvar j = 0; j <= dg_pkg::code_distance_z; j++) begin : g_ew_col
                if (j == 0) begin : g_first
                    neighbor_link #(
                        .kind(dg_pkg::link_boundary),
                        .weight(dg_pkg::weight_z)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j, k)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_west]),
                        .b_view()
                    );
                end else if (j < dg_pkg::code_distance_z) begin : g_inner
                    neighbor_link #(
                        .kind(dg_pkg::link_internal),
                        .weight(dg_pkg::weight_z)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j - 1, k)]),
                        .b_state(states[dg_pkg::pu_index(i, j, k)]),
                        .a_view(views[dg_pkg::pu_index(i, j - 1, k)][dg_pkg::dir_east]),
                        .b_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_west])
                    );
                end else begin : g_last
                    neighbor_link #(
                        .kind(dg_pkg::link_boundary),
                        .weight(dg_pkg::weight_z)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j - 1, k)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i, j - 1, k)][dg_pkg::dir_east]),
                        .b_view()
                    );
                end
            end
        end
    end

    // up/down links between rounds, boundary below the first round
    for (genvar k = 0; k <= dg_pkg::measurement_rounds; k++) begin : g_ud_layer
        for (genvar i = 0; i < dg_pkg::code_distance_x; i++) begin : g_ud_row
            for (genvar j = 0; j < dg_pkg::code_distance_z; j++) begin : g_ud_col
                if (k == 0) begin : g_first
                    neighbor_link #(
                        .kind(dg_pkg::link_boundary),
                        .weight(dg_pkg::weight_m)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j, k)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_down]),
                        .b_view()
                    );
                end else if (k < dg_pkg::measurement_rounds) begin : g_inner
                    neighbor_link #(
                        .kind(dg_pkg::link_internal),
                        .weight(dg_pkg::weight_m)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j, k - 1)]),
                        .b_state(states[dg_pkg::pu_index(i, j, k)]),
                        .a_view(views[dg_pkg::pu_index(i, j, k - 1)][dg_pkg::dir_up]),
                        .b_view(views[dg_pkg::pu_index(i, j, k)][dg_pkg::dir_down])
                    );
                end else begin : g_last
                    // nothing above the last round
                    neighbor_link #(
                        .kind(dg_pkg::link_none),
                        .weight(dg_pkg::weight_m)
                    ) link_i (
                        .clk(clk),
                        .rst_n(rst_n),
                        .global_stage(global_stage),
                        .a_state(states[dg_pkg::pu_index(i, j, k - 1)]),
                        .b_state('0),
                        .a_view(views[dg_pkg::pu_index(i, j, k - 1)][dg_pkg::dir_up]),
                        .b_view()
                    );
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_graph_model.svh
`ifndef TB_GRAPH_MODEL_SVH
`define TB_GRAPH_MODEL_SVH

// lattice position of a unit from its flat index
function automatic int unsigned unit_layer(int unsigned u);
    return u / (dg_pkg::code_distance_x * dg_pkg::code_distance_z);
endfunction

function automatic int unsigned unit_row(int unsigned u);
    return (u % (dg_pkg::code_distance_x * dg_pkg::code_distance_z)) / dg_pkg::code_distance_z;
endfunction

function automatic int unsigned unit_col(int unsigned u);
    return u % dg_pkg::code_distance_z;
endfunction

function automatic dg_pkg::address_t unit_address(int unsigned u);
    return dg_pkg::address_t'((unit_layer(u) << (2 * dg_pkg::per_dim_bit_width)) |
                              (unit_row(u) << dg_pkg::per_dim_bit_width) | unit_col(u));
endfunction

// growth saturates at the weight, the link is filled when it gets there
function automatic bit link_filled(int unsigned defects, int unsigned cycles,
                                   int unsigned weight);
    int unsigned growth;
    growth = defects * cycles;
    if (growth > weight) begin
        growth = weight;
    end
    return growth == weight;
endfunction

task automatic model_clusters(input logic [dg_pkg::pu_count-1:0] meas,
                              input int unsigned cycles,
                              output dg_pkg::address_t [dg_pkg::pu_count-1:0] exp_roots,
                              output logic [dg_pkg::pu_count-1:0] exp_boundary);
    int unsigned v;
    int unsigned weight;
    bit valid;
    for (int u = 0; u < dg_pkg::pu_count; u++) begin
        exp_roots[u] = unit_address(u);
        exp_boundary[u] = (unit_col(u) == 0 && link_filled(meas[u], cycles, dg_pkg::weight_z)) ||
            (unit_col(u) == dg_pkg::code_distance_z - 1 &&
             link_filled(meas[u], cycles, dg_pkg::weight_z)) ||
            (unit_layer(u) == 0 && link_filled(meas[u], cycles, dg_pkg::weight_m));
    end
    // flood min address and boundary contact over filled internal links
    for (int pass = 0; pass < dg_pkg::pu_count; pass++) begin
        for (int u = 0; u < dg_pkg::pu_count; u++) begin
            for (int axis = 0; axis < 3; axis++) begin
                case (axis)
                    0: begin
                        valid = unit_row(u) + 1 < dg_pkg::code_distance_x;
                        v = u + dg_pkg::code_distance_z;
                        weight = dg_pkg::weight_x;
                    end
                    1: begin
                        valid = unit_col(u) + 1 < dg_pkg::code_distance_z;
                        v = u + 1;
                        weight = dg_pkg::weight_z;
                    end
                    default: begin
                        valid = unit_layer(u) + 1 < dg_pkg::measurement_rounds;
                        v = u + dg_pkg::code_distance_x * dg_pkg::code_distance_z;
                        weight = dg_pkg::weight_m;
                    end
                endcase
                if (valid && link_filled(int'(meas[u]) + int'(meas[v]), cycles, weight)) begin
                    if (exp_roots[v] < exp_roots[u]) begin
                        exp_roots[u] = exp_roots[v];
                    end else begin
                        exp_roots[v] = exp_roots[u];
                    end
                    exp_boundary[u] = exp_boundary[u] | exp_boundary[v];
                    exp_boundary[v] = exp_boundary[u];
                end
            end
        end
    end
endtask

`endif

// File: tb_decoding_graph.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decoding_graph;

    localparam int unsigned merge_limit = 40;   // merge cycles before giving up

    logic clk = 1'b0;
    logic rst_n;
    dg_pkg::stage_t global_stage;
    logic [dg_pkg::pu_count-1:0] measurements;
    dg_pkg::address_t [dg_pkg::pu_count-1:0] roots;
    logic [dg_pkg::pu_count-1:0] touching_boundary;
    logic [dg_pkg::pu_count-1:0] busy;

    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    logic [15:0] lfsr_state;

    `include "tb_graph_model.svh"

    decoding_graph dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .global_stage(global_stage),
        .measurements(measurements),
        .roots(roots),
        .touching_boundary(touching_boundary),
        .busy(busy)
    );

    always #2 clk = ~clk;

    // a root or flag change in merge must show up on busy
    for (genvar u = 0; u < dg_pkg::pu_count; u++) begin : g_settle_check
        assert property (@(posedge clk) disable iff (!rst_n)
            ($past(global_stage) == dg_pkg::stage_merge &&
             (roots[u] != $past(roots[u]) ||
              touching_boundary[u] != $past(touching_boundary[u]))) |-> busy[u])
        else begin
            $display("MISMATCH %0t: unit %0d changed in merge without busy", $time, u);
            error_count++;
        end
    end

    // only merge and loading may move the clusters
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(global_stage) == dg_pkg::stage_idle || $past(global_stage) == dg_pkg::stage_grow)
        |-> ($stable(roots) && $stable(touching_boundary)))
    else begin
        $display("MISMATCH %0t: roots or boundary flags moved outside merge", $time);
        error_count++;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic random_bits(input int unsigned count, output logic [31:0] value);
        value = '0;
        for (int unsigned b = 0; b < count; b++) begin
            value[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic set_stage(input dg_pkg::stage_t stage);
        @(posedge clk);
        global_stage <= stage;
    endtask

    task automatic load_measurements(input logic [dg_pkg::pu_count-1:0] meas);
        @(posedge clk);
        global_stage <= dg_pkg::stage_measurement_loading;
        measurements <= meas;
        set_stage(dg_pkg::stage_idle);   // loading edge
        @(negedge clk);
    endtask

    task automatic grow_for(input int unsigned cycles);
        repeat (cycles) set_stage(dg_pkg::stage_grow);
        set_stage(dg_pkg::stage_idle);
    endtask

    task automatic merge_until_settled();
        int unsigned cycles;
        dg_pkg::address_t [dg_pkg::pu_count-1:0] settled_roots;
        logic [dg_pkg::pu_count-1:0] settled_boundary;
        set_stage(dg_pkg::stage_merge);
        @(posedge clk);
        @(negedge clk);
        cycles = 1;
        while (busy != '0 && cycles < merge_limit) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (busy != '0) begin
            $display("timeout: busy did not clear within %0d merge cycles", merge_limit);
            $display("tests failed");
            $finish;
        end else begin
            settled_roots = roots;
            settled_boundary = touching_boundary;
            set_stage(dg_pkg::stage_idle);   // one more merge edge runs here
            @(negedge clk);
            assert (roots == settled_roots && touching_boundary == settled_boundary &&
                    busy == '0)
            else begin
                $display("MISMATCH %0t: extra merge cycle changed a settled graph", $time);
                error_count++;
            end
        end
    endtask

    task automatic check_against_model(input logic [dg_pkg::pu_count-1:0] meas,
                                       input int unsigned cycles, input string what);
        dg_pkg::address_t [dg_pkg::pu_count-1:0] exp_roots;
        logic [dg_pkg::pu_count-1:0] exp_boundary;
        model_clusters(meas, cycles, exp_roots, exp_boundary);
        for (int u = 0; u < dg_pkg::pu_count; u++) begin
            assert (roots[u] == exp_roots[u]) else begin
                $display("MISMATCH %0t: %s unit %0d root %0d, expected %0d",
                         $time, what, u, roots[u], exp_roots[u]);
                error_count++;
            end
            assert (touching_boundary[u] == exp_boundary[u]) else begin
                $display("MISMATCH %0t: %s unit %0d boundary %0b, expected %0b",
                         $time, what, u, touching_boundary[u], exp_boundary[u]);
                error_count++;
            end
        end
        assert (busy == '0) else begin
            $display("MISMATCH %0t: %s busy %h, expected 0", $time, what, busy);
            error_count++;
        end
    endtask

    task automatic run_case(input logic [dg_pkg::pu_count-1:0] meas,
                            input int unsigned cycles, input string what);
        load_measurements(meas);
        check_against_model(meas, 0, what);
        grow_for(cycles);
        merge_until_settled();
        check_against_model(meas, cycles, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        logic [31:0] bits;
        logic [dg_pkg::pu_count-1:0] pattern;
        rst_n = 1'b0;
        global_stage = dg_pkg::stage_idle;
        measurements = '0;
        lfsr_state = 16'd24;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        errors_before = error_count;
        check_against_model('0, 0, "reset");
        load_measurements('0);
        check_against_model('0, 0, "reset");
        finish_test("reset state", errors_before);

        errors_before = error_count;
        run_case('0, 3, "no defects");
        finish_test("no defects", errors_before);

        errors_before = error_count;
        run_case(18'b11, 1, "pair merge");
        assert (roots[1] == '0) else begin
            $display("MISMATCH %0t: pair merge unit 1 root %0d, expected 0", $time, roots[1]);
            error_count++;
        end
        finish_test("pair merge", errors_before);

        errors_before = error_count;
        run_case(18'b1 << 8, 2, "boundary reach");   // row 1, column 0, layer 1
        assert (touching_boundary[8]) else begin
            $display("MISMATCH %0t: boundary reach unit 8 flag low", $time);
            error_count++;
        end
        finish_test("boundary reach", errors_before);

        errors_before = error_count;
        for (int n = 0; n < 20; n++) begin
            random_bits(dg_pkg::pu_count, bits);
            pattern = bits[dg_pkg::pu_count-1:0];
            random_bits(2, bits);
            run_case(pattern, bits % 3 + 1, "random");
        end
        finish_test("random patterns", errors_before);

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
dg_pkg.sv
neighbor_link.sv
processing_unit.sv
decoding_graph.sv
tb_decoding_graph.sv

// File: Bender.yml
package:
  name: decoding_graph

sources:
  - dg_pkg.sv
  - neighbor_link.sv
  - processing_unit.sv
  - decoding_graph.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_decoding_graph.sv
